// ==== fir_filter.f ====
fixpt_pkg.sv
fir_pkg.sv
safe_alu.sv
fir_coef_bank.sv
fir_tap.sv
fir_filter.sv
tb_clock_gen.sv
fir_filter_assertions.sv
fir_filter_tb.sv

// ==== Makefile ====
TOP = fir_filter_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f fir_filter.f \
		--top-module $(TOP) -o $(TOP)

# the run passes only if the pass line shows up in the output
run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

lint:
	verilator --lint-only --timing --assert -Wall -f fir_filter.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== fir_filter_tb.sv ====
`timescale 1ns/100ps

module fir_filter_tb;

  localparam int W        = fixpt_pkg::WORD_SIZE;
  localparam int N        = fixpt_pkg::N_SIZE;
  localparam int NUM_TAPS = fir_pkg::NUM_TAPS;
  localparam int ADDR_W   = fir_pkg::COEF_ADDR_W;

  // samples driven per test set the watchdog length
  localparam int IMPULSE_LEN  = 8;
  localparam int SUB_LEN      = 8;
  localparam int SAT_LEN      = 16;
  localparam int RAND_LEN     = 200;
  localparam int CLEAR_LEN    = 12;
  localparam int TOTAL_LEN    = IMPULSE_LEN + SUB_LEN + SAT_LEN + RAND_LEN + CLEAR_LEN;
  localparam int PERIOD_NS    = 100;
  localparam int RESET_CYCLES = 5;
  localparam int WATCHDOG_NS  = TOTAL_LEN * PERIOD_NS * 4 + RESET_CYCLES * PERIOD_NS;

  typedef logic signed [W-1:0] coef_arr_t [NUM_TAPS];
  typedef fir_pkg::tap_mode_e  mode_arr_t [NUM_TAPS];

  logic                clk;
  logic                reset;
  logic                sample_valid;
  logic signed [W-1:0] sample;
  logic                coef_we;
  logic [ADDR_W-1:0]   coef_addr;
  logic signed [W-1:0] coef_data;
  fir_pkg::tap_mode_e  coef_mode;
  logic                clear;
  logic signed [W-1:0] y;
  logic                y_valid;

  // model image of bank and partial sums
  logic signed [W-1:0] m_coef [NUM_TAPS];
  fir_pkg::tap_mode_e  m_mode [NUM_TAPS];
  logic signed [W-1:0] m_sum  [NUM_TAPS];

  logic signed [W-1:0] exp_q [$];  // expected y values in sample order
  logic signed [W-1:0] exp_y;
  int                  accepted_count;
  int                  strobe_count;
  int                  seed;

  tb_clock_gen #(
    .PERIOD_NS    (PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock (
    .clk_o   (clk),
    .reset_o (reset)
  );

  fir_filter dut_i (
    .clk_i          (clk),
    .reset_i        (reset),
    .sample_valid_i (sample_valid),
    .sample_i       (sample),
    .coef_we_i      (coef_we),
    .coef_addr_i    (coef_addr),
    .coef_data_i    (coef_data),
    .coef_mode_i    (coef_mode),
    .clear_i        (clear),
    .y_o            (y),
    .y_valid_o      (y_valid)
  );

  bind fir_filter fir_filter_assertions u_assertions (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .sample_valid_i (sample_valid_i),
    .clear_i        (clear_i),
    .y_valid_i      (y_valid_o)
  );

  function automatic logic signed [W-1:0] clamp_word(input longint v);
    if (v > longint'(fixpt_pkg::SAT_MAX_16)) return fixpt_pkg::SAT_MAX_16;
    if (v < longint'(fixpt_pkg::SAT_MIN_16)) return fixpt_pkg::SAT_MIN_16;
    return W'(v);
  endfunction

  // exact product floored to the fraction width and then clamped
  function automatic logic signed [W-1:0] mult_trunc(input logic signed [W-1:0] a,
                                                      input logic signed [W-1:0] b);
    longint p;
    p = longint'(a) * longint'(b);
    return clamp_word(p >>> N);
  endfunction

  function automatic logic signed [W-1:0] add_clamped(input logic signed [W-1:0] a,
                                                       input logic signed [W-1:0] b);
    return clamp_word(longint'(a) + longint'(b));
  endfunction

  function automatic logic signed [W-1:0] sub_clamped(input logic signed [W-1:0] a,
                                                       input logic signed [W-1:0] b);
    return clamp_word(longint'(a) - longint'(b));
  endfunction

  // push one accepted sample through the transposed chain and return y
  function automatic logic signed [W-1:0] fir_model(input logic signed [W-1:0] x);
    logic signed [W-1:0] p;
    for (int k = 0; k < NUM_TAPS; k++) begin  // ascending keeps m_sum[k+1] old
      p = mult_trunc(x, m_coef[k]);
      if (k == NUM_TAPS-1) begin
        m_sum[k] = p;  // end of chain ignores the mode
      end else if (m_mode[k] == fir_pkg::TAP_SUB) begin
        m_sum[k] = sub_clamped(m_sum[k+1], p);
      end else begin
        m_sum[k] = add_clamped(m_sum[k+1], p);
      end
    end
    return m_sum[0];
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_sample(input string name, input logic signed [W-1:0] act,
                              input logic signed [W-1:0] exp);
    if (act !== exp) begin
      fail_run($sformatf("Error: %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_strobe(input string name, input int act, input int exp);
    if (act != exp) begin
      fail_run($sformatf("Error: %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  // each stimulus task drives exactly one falling edge
  task automatic idle_cycle();
    @(negedge clk);
    sample_valid = 1'b0;
    coef_we      = 1'b0;
    clear        = 1'b0;
  endtask

  task automatic send_sample(input logic signed [W-1:0] x);
    @(negedge clk);
    sample_valid = 1'b1;
    sample       = x;
    coef_we      = 1'b0;
    clear        = 1'b0;
    exp_q.push_back(fir_model(x));
    accepted_count++;
  endtask

  task automatic write_coef(input logic [ADDR_W-1:0] addr, input logic signed [W-1:0] data,
                            input fir_pkg::tap_mode_e mode);
    @(negedge clk);
    sample_valid = 1'b0;
    clear        = 1'b0;
    coef_we      = 1'b1;
    coef_addr    = addr;
    coef_data    = data;
    coef_mode    = mode;
    if (int'(addr) < NUM_TAPS) begin  // bank drops anything past the last tap
      m_coef[addr] = data;
      m_mode[addr] = mode;
    end
  endtask

  // clear with an optional sample in the same cycle that then gets no strobe
  task automatic send_clear(input logic with_sample, input logic signed [W-1:0] x);
    @(negedge clk);
    clear        = 1'b1;
    sample_valid = with_sample;
    sample       = x;
    coef_we      = 1'b0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      m_sum[k] = '0;
    end
  endtask

  task automatic load_coefs(input coef_arr_t c, input mode_arr_t m);
    for (int k = 0; k < NUM_TAPS; k++) begin
      write_coef(ADDR_W'(k), c[k], m[k]);
    end
  endtask

  // bounded wait for the last strobes before the strobe count check
  task automatic wait_outputs();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 8) begin
      idle_cycle();
      n++;
    end
    check_strobe("y_valid_o count", strobe_count, accepted_count);
  endtask

  task automatic run_impulse();
    coef_arr_t c;
    mode_arr_t m;
    c = '{16'sh2000, 16'sh1000, 16'shf000, 16'sh0800};  // 0.5 0.25 -0.25 0.125
    m = '{fir_pkg::TAP_ADD, fir_pkg::TAP_ADD, fir_pkg::TAP_ADD, fir_pkg::TAP_ADD};
    load_coefs(c, m);
    send_clear(1'b0, '0);
    send_sample(16'sh4000);  // 1.0
    repeat (IMPULSE_LEN-1) send_sample('0);
    wait_outputs();
  endtask

  // tap 1 at +1.0 in sub mode gives y = -x one sample late
  task automatic run_subtract();
    coef_arr_t   c;
    mode_arr_t   m;
    logic signed [W-1:0] xs [SUB_LEN];
    c  = '{16'sh0000, 16'sh4000, 16'sh0000, 16'sh0000};
    m  = '{fir_pkg::TAP_ADD, fir_pkg::TAP_SUB, fir_pkg::TAP_ADD, fir_pkg::TAP_ADD};
    xs = '{16'sh1234, 16'sh8000, 16'sh7fff, 16'shc000,
           16'sh8000, 16'sh0000, 16'sh2000, 16'sh0000};  // -2.0 must clamp to max
    load_coefs(c, m);
    send_clear(1'b0, '0);
    for (int i = 0; i < SUB_LEN; i++) begin
      send_sample(xs[i]);
    end
    wait_outputs();
  endtask

  task automatic run_saturation();
    coef_arr_t c;
    mode_arr_t m;
    c = '{16'sh7fff, 16'sh8000, 16'sh7fff, 16'sh6000};
    m = '{fir_pkg::TAP_ADD, fir_pkg::TAP_SUB, fir_pkg::TAP_ADD, fir_pkg::TAP_ADD};
    load_coefs(c, m);
    send_clear(1'b0, '0);
    for (int i = 0; i < SAT_LEN; i++) begin  // full scale in both signs
      send_sample((i[0] ^ i[2]) ? fixpt_pkg::SAT_MIN_16 : fixpt_pkg::SAT_MAX_16);
    end
    wait_outputs();
  endtask

  task automatic run_random();
    int gap;
    send_clear(1'b0, '0);
    for (int i = 0; i < RAND_LEN; i++) begin
      if (i % 50 == 0) begin  // new bank mid stream keeps the history
        for (int k = 0; k < NUM_TAPS; k++) begin
          write_coef(ADDR_W'(k), W'($random(seed)),
                     (($random(seed) & 1) != 0) ? fir_pkg::TAP_SUB : fir_pkg::TAP_ADD);
        end
      end
      send_sample(W'($random(seed)));
      gap = $random(seed) & 3;
      if (gap == 3) gap = 0;  // half back to back
      repeat (gap) idle_cycle();
    end
    wait_outputs();
  endtask

  task automatic run_clear_rewrite();
    coef_arr_t c;
    mode_arr_t m;
    c = '{16'sh4000, 16'sh4000, 16'sh4000, 16'sh4000};
    m = '{fir_pkg::TAP_ADD, fir_pkg::TAP_ADD, fir_pkg::TAP_ADD, fir_pkg::TAP_ADD};
    load_coefs(c, m);
    send_clear(1'b0, '0);
    repeat (4) send_sample(16'sh1000);  // build up history
    send_clear(1'b0, '0);
    send_sample(16'sh1000);  // only tap 0 product now
    send_sample(16'sh0800);
    write_coef(ADDR_W'(0), 16'sh2000, fir_pkg::TAP_ADD);  // between samples
    repeat (3) send_sample(16'sh1000);
    send_clear(1'b1, 16'sh1000);  // clear wins and no strobe follows
    send_sample(16'sh1000);
    send_sample(16'sh2000);
    wait_outputs();
  endtask

  // compare on every strobe while outputs are settled at the falling edge
  always @(negedge clk) begin
    if (dut_i.u_assertions.fail_count != 0) begin
      fail_run("a bound assertion on y_valid_o failed");
    end
    if (y_valid === 1'b1) begin
      strobe_count++;  // a strobe with nothing pending shows up in the count
      if (exp_q.size() != 0) begin
        exp_y = exp_q.pop_front();
        check_sample("y_o", y, exp_y);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    seed           = 32'h55cd;
    sample_valid   = 1'b0;
    sample         = '0;
    coef_we        = 1'b0;
    coef_addr      = '0;
    coef_data      = '0;
    coef_mode      = fir_pkg::TAP_ADD;
    clear          = 1'b0;
    accepted_count = 0;
    strobe_count   = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin  // reset state of the bank
      m_coef[k] = '0;
      m_mode[k] = fir_pkg::TAP_ADD;
      m_sum[k]  = '0;
    end

    @(negedge clk);
    while (reset !== 1'b0) @(negedge clk);

    run_impulse();
    run_subtract();
    run_saturation();
    run_random();
    run_clear_rewrite();

    if (exp_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      fail_run("expected outputs still pending at the end of the run");
    end
  end

endmodule

// ==== fir_filter_assertions.sv ====
`timescale 1ns/100ps

module fir_filter_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic sample_valid_i,
  input logic clear_i,
  input logic y_valid_i        // dut y_valid_o
);

  logic sample_taken;  // sample that must produce a strobe
  int   fail_count = 0;  // failed assertions so far

  assign sample_taken = sample_valid_i && !clear_i && !reset_i;

  // strobe exactly one cycle after an accepted sample
  a_strobe_after_sample: assert property (
    @(posedge clk_i) sample_taken |=> y_valid_i
  ) else begin
    fail_count++;
    $error("y_valid_o missing one cycle after an accepted sample");
  end

  // no strobe unless the previous cycle took a sample
  a_no_stray_strobe: assert property (
    @(posedge clk_i) y_valid_i |-> $past(sample_taken)
  ) else begin
    fail_count++;
    $error("y_valid_o high without an accepted sample before it");
  end

  // reset forces the strobe low
  a_quiet_in_reset: assert property (
    @(posedge clk_i) reset_i |=> !y_valid_i
  ) else begin
    fail_count++;
    $error("y_valid_o high after a reset edge");
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic reset_o   // synchronous, active high
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS/2) clk_o = ~clk_o;  // half period each phase
  end

  // reset seen high on the first RESET_CYCLES rising edges
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== fir_filter.sv ====
`timescale 1ns/100ps

module fir_filter #(
  parameter int WORD_SIZE   = fixpt_pkg::WORD_SIZE,
  parameter int N_SIZE      = fixpt_pkg::N_SIZE,
  parameter int NUM_TAPS    = fir_pkg::NUM_TAPS,
  parameter int COEF_ADDR_W = fir_pkg::COEF_ADDR_W
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         sample_valid_i,  // one cycle per sample
  input  logic signed [WORD_SIZE-1:0]  sample_i,        // q1.14 input
  input  logic                         coef_we_i,       // coefficient write strobe
  input  logic        [COEF_ADDR_W-1:0] coef_addr_i,
  input  logic signed [WORD_SIZE-1:0]  coef_data_i,
  input  fir_pkg::tap_mode_e           coef_mode_i,
  input  logic                         clear_i,         // empty the partial sums
  output logic signed [WORD_SIZE-1:0]  y_o,             // tap 0 partial sum
  output logic                         y_valid_o        // one cycle after sample
);

  logic [NUM_TAPS*WORD_SIZE-1:0]     coef_bus;  // packed per tap
  fir_pkg::tap_mode_e [NUM_TAPS-1:0] mode_bus;

  // sum_chain[k] is tap k's output, sum_chain[NUM_TAPS] feeds the last tap
  logic signed [WORD_SIZE-1:0] sum_chain [NUM_TAPS+1];

  logic y_valid_q;

  fir_coef_bank #(
    .WORD_SIZE   (WORD_SIZE),
    .NUM_TAPS    (NUM_TAPS),
    .COEF_ADDR_W (COEF_ADDR_W)
  ) u_bank (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .coef_we_i   (coef_we_i),
    .coef_addr_i (coef_addr_i),
    .coef_data_i (coef_data_i),
    .coef_mode_i (coef_mode_i),
    .coef_bus_o  (coef_bus),
    .mode_bus_o  (mode_bus)
  );

  assign sum_chain[NUM_TAPS] = '0;  // last tap ignores it

  // transposed form, sums flow from the high tap down to tap 0
  for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
    fir_tap #(
      .WORD_SIZE (WORD_SIZE),
      .N_SIZE    (N_SIZE),
      .IS_LAST   (k == NUM_TAPS-1)
    ) u_tap (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .sample_valid_i (sample_valid_i),
      .clear_i        (clear_i),
      .sample_i       (sample_i),                                // same x to all
      .coef_i         (coef_bus[k*WORD_SIZE +: WORD_SIZE]),
      .mode_i         (mode_bus[k]),
      .sum_i          (sum_chain[k+1]),
      .sum_o          (sum_chain[k])
    );
  end

  assign y_o = sum_chain[0];

  // output strobe tracks the tap registers, no strobe on a cleared sample
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      y_valid_q <= 1'b0;
    end else begin
      y_valid_q <= sample_valid_i && !clear_i;
    end
  end

  assign y_valid_o = y_valid_q;

endmodule

// ==== fir_tap.sv ====
`timescale 1ns/100ps

module fir_tap #(
  parameter int WORD_SIZE = 16,
  parameter int N_SIZE    = 14,
  parameter bit IS_LAST   = 1'b0   // end of chain, no incoming sum
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         sample_valid_i,  // advance strobe
  input  logic                         clear_i,         // zero the partial sum
  input  logic signed [WORD_SIZE-1:0]  sample_i,        // broadcast x
  input  logic signed [WORD_SIZE-1:0]  coef_i,          // c_k from bank
  input  fir_pkg::tap_mode_e           mode_i,          // add or sub
  input  logic signed [WORD_SIZE-1:0]  sum_i,           // s_k+1 from prior sample
  output logic signed [WORD_SIZE-1:0]  sum_o            // registered s_k
);

  logic signed [WORD_SIZE-1:0] prod;      // p_k, clamped
  logic signed [WORD_SIZE-1:0] sum_next;  // value to load
  logic signed [WORD_SIZE-1:0] sum_q;

  // p_k = c_k * x
  safe_alu #(
    .WORD_SIZE (WORD_SIZE),
    .N_SIZE    (N_SIZE),
    .OPERATION (fixpt_pkg::ALU_MULT)
  ) u_mult (
    .a_i    (sample_i),
    .b_i    (coef_i),
    .data_o (prod)
  );

  if (IS_LAST) begin : g_last
    // last stage just holds the product
    assign sum_next = prod;
  end else begin : g_mid
    logic signed [WORD_SIZE-1:0] sum_add;
    logic signed [WORD_SIZE-1:0] sum_sub;

    safe_alu #(
      .WORD_SIZE (WORD_SIZE),
      .N_SIZE    (N_SIZE),
      .OPERATION (fixpt_pkg::ALU_ADD)
    ) u_add (
      .a_i    (sum_i),
      .b_i    (prod),
      .data_o (sum_add)
    );

    // sum minus product, so +1.0 coef gives gain -1.0 cleanly
    safe_alu #(
      .WORD_SIZE (WORD_SIZE),
      .N_SIZE    (N_SIZE),
      .OPERATION (fixpt_pkg::ALU_SUB)
    ) u_sub (
      .a_i    (sum_i),
      .b_i    (prod),
      .data_o (sum_sub)
    );

    assign sum_next = (mode_i == fir_pkg::TAP_SUB) ? sum_sub : sum_add;
  end

  // partial sum register, clear beats a sample in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      sum_q <= '0;
    end else if (sample_valid_i) begin
      sum_q <= sum_next;  // one cycle per stage
    end
  end

  assign sum_o = sum_q;

endmodule

// ==== fir_coef_bank.sv ====
`timescale 1ns/100ps

module fir_coef_bank #(
  parameter int WORD_SIZE   = 16,
  parameter int NUM_TAPS    = 4,
  parameter int COEF_ADDR_W = 2
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 coef_we_i,    // write strobe
  input  logic               [COEF_ADDR_W-1:0] coef_addr_i,  // tap index
  input  logic signed        [WORD_SIZE-1:0]   coef_data_i,
  input  fir_pkg::tap_mode_e                   coef_mode_i,
  output logic [NUM_TAPS*WORD_SIZE-1:0]        coef_bus_o,   // tap k at k*WORD_SIZE
  output fir_pkg::tap_mode_e [NUM_TAPS-1:0]    mode_bus_o    // one mode per tap
);

  // one entry per tap
  logic signed [WORD_SIZE-1:0] coef_q [NUM_TAPS];
  fir_pkg::tap_mode_e          mode_q [NUM_TAPS];

  logic addr_ok;  // address names a real tap

  assign addr_ok = (int'(coef_addr_i) < NUM_TAPS);

  // after reset every tap is zero gain in add mode
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        coef_q[k] <= '0;
        mode_q[k] <= fir_pkg::TAP_ADD;
      end
    end else if (coef_we_i && addr_ok) begin
      coef_q[coef_addr_i] <= coef_data_i;  // seen by taps next cycle
      mode_q[coef_addr_i] <= coef_mode_i;
    end
    // out of range writes just drop
  end

  // every entry visible at once, no read port
  for (genvar k = 0; k < NUM_TAPS; k++) begin : g_bus
    assign coef_bus_o[k*WORD_SIZE +: WORD_SIZE] = coef_q[k];
    assign mode_bus_o[k]                        = mode_q[k];
  end

endmodule

// ==== safe_alu.sv ====
`timescale 1ns/100ps

module safe_alu #(
  parameter int                 WORD_SIZE = 16,
  parameter int                 N_SIZE    = 14,
  parameter fixpt_pkg::alu_op_e OPERATION = fixpt_pkg::ALU_ADD
) (
  input  logic signed [WORD_SIZE-1:0] a_i,     // operand a
  input  logic signed [WORD_SIZE-1:0] b_i,     // operand b
  output logic signed [WORD_SIZE-1:0] data_o   // clamped result
);

  // integer bits of qm.n, sign not counted
  localparam int M_SIZE = WORD_SIZE - N_SIZE - 1;

  // clamp values for this word size
  localparam logic signed [WORD_SIZE-1:0] SAT_MAX = {1'b0, {(WORD_SIZE-1){1'b1}}};
  localparam logic signed [WORD_SIZE-1:0] SAT_MIN = {1'b1, {(WORD_SIZE-1){1'b0}}};

  // purely combinational, caller registers around it
  generate
    case (OPERATION)

      fixpt_pkg::ALU_ADD, fixpt_pkg::ALU_SUB: begin : g_addsub
        // one guard bit catches the carry into the sign
        localparam bit IS_SUB = (OPERATION == fixpt_pkg::ALU_SUB);

        logic signed [WORD_SIZE:0] a_ext;
        logic signed [WORD_SIZE:0] b_ext;
        logic signed [WORD_SIZE:0] res_ext;

        always_comb begin
          a_ext = a_i;  // sign extended
          b_ext = b_i;
          if (IS_SUB) begin
            res_ext = a_ext - b_ext;  // -min fits in the guard width
          end else begin
            res_ext = a_ext + b_ext;
          end

          // guard and sign disagree on overflow
          unique case (res_ext[WORD_SIZE -: 2])
            2'b01:   data_o = SAT_MAX;  // positive wrap
            2'b10:   data_o = SAT_MIN;  // negative wrap
            default: data_o = res_ext[WORD_SIZE-1:0];
          endcase
        end
      end

      fixpt_pkg::ALU_MULT: begin : g_mult
        // full product is q(2m+1).(2n), keep the qm.n window
        localparam int MSB    = 2*WORD_SIZE - 1;
        localparam int HI_LSB = MSB - M_SIZE - 1;  // top bit of kept slice

        logic signed [2*WORD_SIZE-1:0] prod;
        logic        [M_SIZE+1:0]      prod_hi;   // dropped bits plus kept sign

        always_comb begin
          prod    = a_i * b_i;  // exact, no rounding
          prod_hi = prod[MSB:HI_LSB];
          data_o  = prod[HI_LSB:N_SIZE];  // truncate low fraction bits

          // dropped high bits must all match the sign
          if (prod[MSB] && !(&prod_hi)) begin
            data_o = SAT_MIN;  // too negative
          end
          if (!prod[MSB] && (|prod_hi)) begin
            data_o = SAT_MAX;  // too positive
          end
        end
      end

      default: begin : g_bad_op
        $error("safe_alu: unsupported OPERATION");
      end

    endcase
  endgenerate

endmodule

// ==== fir_pkg.sv ====
package fir_pkg;

  // filter size defaults
  parameter int NUM_TAPS    = 4;  // taps in the chain
  parameter int COEF_ADDR_W = 2;  // bank address width

  // per-tap mode, how the product joins the partial sum
  // subtract mode covers gain -1.0, since +1.0 with sub gives it exactly
  typedef enum logic {
    TAP_ADD = 1'b0,  // s_k = s_k+1 + p_k
    TAP_SUB = 1'b1   // s_k = s_k+1 - p_k
  } tap_mode_e;

endpackage

// ==== fixpt_pkg.sv ====
package fixpt_pkg;

  // default word and q-format split
  // samples and coefficients are Q1.14 in a 16 bit word
  parameter int WORD_SIZE = 16;  // total bits, sign included
  parameter int N_SIZE    = 14;  // fraction bits

  // integer bits (m) come from WORD_SIZE and N_SIZE inside safe_alu

  // saturation limits at the default width
  parameter logic signed [15:0] SAT_MAX_16 = 16'sh7fff;  // just under +2.0
  parameter logic signed [15:0] SAT_MIN_16 = 16'sh8000;  // exactly -2.0

  // arithmetic opcode for safe_alu
  typedef enum logic [1:0] {
    ALU_ADD  = 2'd0,  // a + b, clamped
    ALU_SUB  = 2'd1,  // a - b, clamped
    ALU_MULT = 2'd2   // a * b, qm.n slice, clamped
  } alu_op_e;

endpackage
